/* common/dma_stats_pkg.sv */
// widths, register map, statistic indices, control word union, reset stretch length

package dma_stats_pkg;

   // --------------------------------------------------
   // bus and storage widths
   // --------------------------------------------------
   localparam int data_width          = 32;
   localparam int reg_addr_width      = 6;
   localparam int num_stats           = 5;
   // control word plus one word per statistic
   localparam int num_regs            = 6;
   localparam int reg_file_addr_width = 3;
   localparam int pkt_len_width       = 12;
   // one spare bit over the packet length
   localparam int delta_width         = 13;

   // --------------------------------------------------
   // register map, statistic k lives at address k+1
   // --------------------------------------------------
   localparam logic [reg_addr_width-1:0] addr_control       = 6'd0;
   localparam logic [reg_addr_width-1:0] addr_ingress_pkts  = 6'd1;
   localparam logic [reg_addr_width-1:0] addr_ingress_bytes = 6'd2;
   localparam logic [reg_addr_width-1:0] addr_egress_pkts   = 6'd3;
   localparam logic [reg_addr_width-1:0] addr_egress_bytes  = 6'd4;
   localparam logic [reg_addr_width-1:0] addr_timeouts      = 6'd5;

   // statistic slots in the delta vectors
   localparam int stat_ingress_pkts  = 0;
   localparam int stat_ingress_bytes = 1;
   localparam int stat_egress_pkts   = 2;
   localparam int stat_egress_bytes  = 3;
   localparam int stat_timeouts      = 4;

   // --------------------------------------------------
   // control word
   // --------------------------------------------------
   localparam int ctrl_disable_pos     = 0;
   localparam int ctrl_reset_pos       = 1;
   localparam int reset_stretch_cycles = 32;

   // returned for anything outside the map
   localparam logic [data_width-1:0] bad_addr_data = 32'hdead_beef;

   // raw view as the host writes it, field view for decoding
   typedef union packed {
      logic [data_width-1:0] raw;
      struct packed {
         logic [data_width-3:0] spare;
         logic                  iface_reset;
         logic                  iface_disable;
      } fields;
   } ctrl_word_t;

endpackage

/* dma_regs/stat_delta_accum.sv */
`timescale 1ns/1ps
// delta accumulator for one statistic, restarted by its commit strobe

module stat_delta_accum (
   input  logic                                  clk,
   input  logic                                  reset,
   // increment for this cycle, zero when idle
   input  logic [dma_stats_pkg::delta_width-1:0] incr,
   // high while the ram word takes the delta
   input  logic                                  commit_strobe,
   output logic [dma_stats_pkg::delta_width-1:0] delta
);

   // --------------------------------------------------
   // accumulate between commits
   // --------------------------------------------------
   // the register file adds delta to ram in the
   // strobe cycle, so the restart value is this
   // cycle's increment and not zero
   always_ff @(posedge clk) begin
      if (reset) begin
         delta <= '0;
      end
      else if (commit_strobe) begin
         // old value goes to ram, keep new event
         delta <= incr;
      end
      else begin
         // running sum since last commit
         delta <= delta + incr;
      end
   end

   // width check against the commit period
   // worst case six commit cycles apart plus
   // paused cycles from host requests, at most
   // one large packet every few cycles, so the
   // extra bit over pkt_len holds the sum

endmodule

/* dma_regs/stat_reg_file.sv */
`timescale 1ns/1ps
// register ram with clear sweep, round-robin delta commit, host access, control register

module stat_reg_file (
   input  logic                                     clk,
   input  logic                                     reset,
   // host bus
   input  logic                                     reg_req,
   input  logic                                     reg_rd_wr_l,
   input  logic [dma_stats_pkg::reg_addr_width-1:0] reg_addr,
   input  logic [dma_stats_pkg::data_width-1:0]     reg_wr_data,
   output logic [dma_stats_pkg::data_width-1:0]     reg_rd_data,
   output logic                                     reg_ack,
   // accumulator side
   input  logic [dma_stats_pkg::num_stats-1:0][dma_stats_pkg::delta_width-1:0] deltas,
   output logic [dma_stats_pkg::num_stats-1:0]      commit_strobe,
   // dma control
   output logic                                     iface_disable,
   output logic                                     iface_reset
);
   import dma_stats_pkg::*;

   // single port register ram
   logic [data_width-1:0]          reg_file [num_regs];
   logic [reg_file_addr_width-1:0] ram_addr;
   logic                           ram_wr;
   logic [data_width-1:0]          ram_wr_data;
   logic [data_width-1:0]          ram_rd_data;

   // sweep and round-robin pointer
   logic                           sweeping;
   logic                           sweeping_nxt;
   logic [reg_file_addr_width-1:0] reg_cnt;
   logic [reg_file_addr_width-1:0] reg_cnt_nxt;
   logic                           last_reg;

   // host request decode
   logic                           reg_req_d1;
   logic                           new_reg_req;
   logic [reg_file_addr_width-1:0] host_addr;
   logic                           addr_good;
   logic                           host_wr;
   logic                           ctrl_wr;

   // commit path
   logic                           commit_cycle;
   logic [delta_width-1:0]         delta_sel;
   logic [data_width-1:0]          delta_ext;

   // control register and reset stretch
   ctrl_word_t                     control_reg;
   logic [reset_stretch_cycles-2:0] reset_stretch;

   // --------------------------------------------------
   // ram
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (ram_wr)
         reg_file[ram_addr] <= ram_wr_data;
   end

   // async read with the address always inside the map
   assign ram_rd_data = reg_file[ram_addr];

   // --------------------------------------------------
   // request decode
   // --------------------------------------------------
   // rising edge of the level request
   assign new_reg_req = reg_req && !reg_req_d1;
   assign host_addr   = reg_addr[reg_file_addr_width-1:0];
   // upper address bits zero and index below num_regs
   assign addr_good   = (reg_addr[reg_addr_width-1:reg_file_addr_width] == '0) &&
                        (host_addr < reg_file_addr_width'(num_regs));
   assign host_wr     = addr_good && !reg_rd_wr_l;
   assign ctrl_wr     = !sweeping && new_reg_req && host_wr && (reg_addr == addr_control);

   // request edge takes the ram port for its cycle
   assign commit_cycle = !sweeping && !new_reg_req;
   assign last_reg     = (reg_cnt == reg_file_addr_width'(num_regs - 1));

   // --------------------------------------------------
   // commit strobes and delta select
   // --------------------------------------------------
   always_comb begin
      commit_strobe = '0;
      delta_sel     = '0;
      for (int k = 0; k < num_stats; k++) begin
         // statistic k sits one above the control word
         if (commit_cycle &&
             reg_cnt == reg_file_addr_width'(addr_ingress_pkts) + reg_file_addr_width'(k)) begin
            commit_strobe[k] = 1'b1;
            delta_sel        = deltas[k];
         end
      end
   end

   assign delta_ext = {{(data_width - delta_width){delta_sel[delta_width-1]}}, delta_sel};

   // --------------------------------------------------
   // ram port arbitration
   // --------------------------------------------------
   always_comb begin
      sweeping_nxt = sweeping;
      reg_cnt_nxt  = reg_cnt;
      ram_addr     = reg_cnt;
      ram_wr       = 1'b0;
      ram_wr_data  = '0;

      if (sweeping) begin
         // zero one word per cycle
         ram_wr = 1'b1;
         if (last_reg) begin
            sweeping_nxt = 1'b0;
            reg_cnt_nxt  = '0;
         end
         else begin
            reg_cnt_nxt = reg_cnt + 1'b1;
         end
      end
      else if (new_reg_req) begin
         // host access while the commit pointer holds
         if (addr_good)
            ram_addr = host_addr;
         ram_wr      = host_wr;
         ram_wr_data = reg_wr_data;
      end
      else begin
         // read-modify-write of the current word
         // control word gets a zero delta
         ram_wr      = 1'b1;
         ram_wr_data = ram_rd_data + delta_ext;
         if (last_reg)
            reg_cnt_nxt = '0;
         else
            reg_cnt_nxt = reg_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         sweeping   <= 1'b1;
         reg_cnt    <= '0;
         reg_req_d1 <= 1'b0;
         reg_ack    <= 1'b0;
      end
      else begin
         sweeping   <= sweeping_nxt;
         reg_cnt    <= reg_cnt_nxt;
         reg_req_d1 <= reg_req;
         // one-cycle ack after every edge
         reg_ack    <= new_reg_req;
      end
   end

   // --------------------------------------------------
   // host read data
   // --------------------------------------------------
   // reset bit has cleared itself before the next request edge
   always_ff @(posedge clk) begin
      if (new_reg_req) begin
         if (!addr_good)
            reg_rd_data <= bad_addr_data;
         else if (reg_addr == addr_control)
            reg_rd_data <= control_reg.raw;
         else
            reg_rd_data <= ram_rd_data;
      end
   end

   // --------------------------------------------------
   // control register and reset stretch
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         control_reg.raw <= '0;
      end
      else if (ctrl_wr) begin
         control_reg.raw <= reg_wr_data;
      end
      else begin
         // reset bit lasts one cycle
         control_reg.fields.iface_reset <= 1'b0;
      end
   end

   // delayed copies of the one-cycle reset bit
   always_ff @(posedge clk) begin
      if (reset)
         reset_stretch <= '0;
      else
         reset_stretch <= {reset_stretch[reset_stretch_cycles-3:0],
                           control_reg.fields.iface_reset};
   end

   assign iface_disable = control_reg.fields.iface_disable;
   // live bit plus shifted copies for 32 cycles in total
   assign iface_reset   = control_reg.fields.iface_reset | (|reset_stretch);

endmodule

/* dma_stats.f */
+incdir+verification
common/dma_stats_pkg.sv
rtl/stat_event_router.sv
dma_regs/stat_delta_accum.sv
dma_regs/stat_reg_file.sv
rtl/dma_stats_top.sv
verification/dma_stats_tb.sv

/* rtl/dma_stats_top.sv */
`timescale 1ns/1ps
// top level of the dma queue statistics block, router, accumulators, register file

module dma_stats_top (
   input  logic                                     clk,
   input  logic                                     reset,
   // host bus
   input  logic                                     reg_req,
   input  logic                                     reg_rd_wr_l,
   input  logic [dma_stats_pkg::reg_addr_width-1:0] reg_addr,
   input  logic [dma_stats_pkg::data_width-1:0]     reg_wr_data,
   output logic [dma_stats_pkg::data_width-1:0]     reg_rd_data,
   output logic                                     reg_ack,
   // dma engine events
   input  logic                                     pkt_ingress,
   input  logic                                     pkt_egress,
   input  logic [dma_stats_pkg::pkt_len_width-1:0]  pkt_len,
   input  logic                                     timeout,
   // dma control
   output logic                                     iface_disable,
   output logic                                     iface_reset
);
   import dma_stats_pkg::*;

   // increments from the router, one slot per statistic
   logic [num_stats-1:0][delta_width-1:0] incr;
   // pending deltas toward the register file
   logic [num_stats-1:0][delta_width-1:0] deltas;
   logic [num_stats-1:0]                  commit_strobe;

   // --------------------------------------------------
   // event routing
   // --------------------------------------------------
   stat_event_router stat_event_router_i (
      .pkt_ingress (pkt_ingress),
      .pkt_egress  (pkt_egress),
      .pkt_len     (pkt_len),
      .timeout     (timeout),
      .incr        (incr)
   );

   // one accumulator per statistic
   for (genvar k = 0; k < num_stats; k++) begin : g_accum
      stat_delta_accum stat_delta_accum_i (
         .clk           (clk),
         .reset         (reset),
         .incr          (incr[k]),
         .commit_strobe (commit_strobe[k]),
         .delta         (deltas[k])
      );
   end

   // --------------------------------------------------
   // ram, host access and control
   // --------------------------------------------------
   stat_reg_file stat_reg_file_i (
      .clk           (clk),
      .reset         (reset),
      .reg_req       (reg_req),
      .reg_rd_wr_l   (reg_rd_wr_l),
      .reg_addr      (reg_addr),
      .reg_wr_data   (reg_wr_data),
      .reg_rd_data   (reg_rd_data),
      .reg_ack       (reg_ack),
      .deltas        (deltas),
      .commit_strobe (commit_strobe),
      .iface_disable (iface_disable),
      .iface_reset   (iface_reset)
   );

endmodule

/* rtl/stat_event_router.sv */
`timescale 1ns/1ps
// event router from dma strobes and packet length to per-statistic increments

module stat_event_router (
   input  logic                                     pkt_ingress,
   input  logic                                     pkt_egress,
   input  logic [dma_stats_pkg::pkt_len_width-1:0]  pkt_len,
   input  logic                                     timeout,
   output logic [dma_stats_pkg::num_stats-1:0][dma_stats_pkg::delta_width-1:0] incr
);
   import dma_stats_pkg::*;

   // length widened to accumulator size
   logic [delta_width-1:0] len_ext;
   // single count, used by the packet and timeout slots
   logic [delta_width-1:0] one;

   assign len_ext = {{(delta_width - pkt_len_width){1'b0}}, pkt_len};
   assign one     = {{(delta_width - 1){1'b0}}, 1'b1};

   // --------------------------------------------------
   // event to statistic mapping
   // --------------------------------------------------
   always_comb begin
      // idle slots carry zero
      incr = '0;

      // ingress side
      if (pkt_ingress) begin
         incr[stat_ingress_pkts]  = one;
         incr[stat_ingress_bytes] = len_ext;
      end

      // egress side, may coincide with ingress
      // both share the same length bus
      if (pkt_egress) begin
         incr[stat_egress_pkts]  = one;
         incr[stat_egress_bytes] = len_ext;
      end

      // timeouts carry no length
      if (timeout) begin
         incr[stat_timeouts] = one;
      end
   end

   // nothing registered here
   // accumulators see the increments in the same cycle

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# builds the dma statistics testbench with verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir

verilator --binary --timing --assert --top-module dma_stats_tb \
   -f dma_stats.f -Mdir "$obj_dir"
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

output=$("$obj_dir/Vdma_stats_tb")
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "TEST PASSED"; then
   exit 0
else
   echo "pass line not found in simulation output"
   exit 1
fi

/* verification/dma_stats_tb_tasks.svh */
// event driving, host bus access, settle wait and check tasks for the dma stats testbench

// --------------------------------------------------
// event stimulus
// --------------------------------------------------
// one clock step of events, reference totals follow the event map
task automatic drive_events(input logic ing, input logic egr, input logic tmo,
                            input logic [pkt_len_width-1:0] len);
   @(posedge clk);
   pkt_ingress <= ing;
   pkt_egress  <= egr;
   timeout     <= tmo;
   pkt_len     <= len;
   if (ing) begin
      ref_stats[stat_ingress_pkts]  += 32'd1;
      ref_stats[stat_ingress_bytes] += data_width'(len);
   end
   if (egr) begin
      ref_stats[stat_egress_pkts]  += 32'd1;
      ref_stats[stat_egress_bytes] += data_width'(len);
   end
   if (tmo)
      ref_stats[stat_timeouts] += 32'd1;
endtask

// lengths up to 255, so even a long commit gap stays below the delta sign bit
task automatic random_step();
   logic [31:0] r;
   r = $random(seed);
   drive_events(r[0], r[1], r[2], pkt_len_width'(r[15:8]));
endtask

// idle step or random events while the bus is busy
task automatic step_cycle(input bit busy);
   if (busy)
      random_step();
   else
      drive_events(1'b0, 1'b0, 1'b0, '0);
endtask

// --------------------------------------------------
// host bus
// --------------------------------------------------
// level request, ack due in the cycle after the edge
task automatic bus_access(input logic rd, input logic [reg_addr_width-1:0] addr,
                          input logic [data_width-1:0] data, input bit busy,
                          output logic [data_width-1:0] rd_data);
   int waited;
   bit acked;
   waited  = 0;
   acked   = 0;
   rd_data = '0;
   step_cycle(busy);
   reg_req     <= 1'b1;
   reg_rd_wr_l <= rd;
   reg_addr    <= addr;
   reg_wr_data <= data;
   while (!acked && waited < 4) begin
      @(negedge clk);
      waited++;
      if (reg_ack) begin
         acked     = 1;
         rd_data   = reg_rd_data;
         ack_cycle = cycle;
      end
      else begin
         step_cycle(busy);
      end
   end
   assert (acked && waited == 2)
   else begin
      errors++;
      $display("Error at %0t: ack for addr %0d missing or late", $time, addr);
   end
   // drop the request, ack must be gone by now
   step_cycle(busy);
   reg_req <= 1'b0;
   @(negedge clk);
   assert (!reg_ack)
   else begin
      errors++;
      $display("Error at %0t: ack for addr %0d held longer than one cycle", $time, addr);
   end
endtask

task automatic write_reg(input logic [reg_addr_width-1:0] addr,
                         input logic [data_width-1:0] data);
   logic [data_width-1:0] ignored;
   bus_access(1'b0, addr, data, 1'b0, ignored);
   // counters sit at addresses 1 to 5
   if (addr >= 6'd1 && addr <= 6'd5)
      ref_stats[addr[2:0] - 3'd1] = data;
endtask

task automatic check_read(input logic [reg_addr_width-1:0] addr,
                          input logic [data_width-1:0] exp_val);
   logic [data_width-1:0] got;
   bus_access(1'b1, addr, '0, 1'b0, got);
   assert (got === exp_val)
   else begin
      errors++;
      $display("Error at %0t: addr %0d read %h, expected %h", $time, addr, got, exp_val);
   end
endtask

// back-to-back reads, commits pause on every edge
task automatic busy_reads(input logic [7:0] n);
   logic [data_width-1:0] ignored;
   for (int k = 0; k < int'(n); k++)
      bus_access(1'b1, reg_addr_width'(k % num_regs), '0, 1'b1, ignored);
endtask

/* verification/dma_stats_tb.sv */
`timescale 1ns/1ps
// dma stats testbench with stimulus table, reference totals, pin checks and timeout

module dma_stats_tb;
   import dma_stats_pkg::*;

   logic                      clk;
   logic                      reset;
   logic                      reg_req;
   logic                      reg_rd_wr_l;
   logic [reg_addr_width-1:0] reg_addr;
   logic [data_width-1:0]     reg_wr_data;
   logic [data_width-1:0]     reg_rd_data;
   logic                      reg_ack;
   logic                      pkt_ingress;
   logic                      pkt_egress;
   logic [pkt_len_width-1:0]  pkt_len;
   logic                      timeout;
   logic                      iface_disable;
   logic                      iface_reset;

   // --------------------------------------------------
   // stimulus table
   // --------------------------------------------------
   typedef enum logic [3:0] {
      op_event, op_random, op_write, op_read, op_busy,
      op_settle, op_check_all, op_pins, op_pulse
   } op_t;

   // pins rows compare exp_data[1:0] with {iface_reset, iface_disable}
   typedef struct packed {
      op_t                       op;
      logic                      ing;
      logic                      egr;
      logic                      tmo;
      logic [pkt_len_width-1:0]  len;
      logic [reg_addr_width-1:0] addr;
      logic [data_width-1:0]     data;
      logic [data_width-1:0]     exp_data;
      logic [7:0]                cycles;
   } row_t;

   localparam int num_rows       = 36;
   localparam int timeout_cycles = num_rows * 40 + 200;

   row_t stim [num_rows] = '{
      // reset state and cleared ram
      '{op_pins,      1'b0, 1'b0, 1'b0, 12'd0,    6'd0,  32'h0,         32'h0,         8'd0},
      '{op_read,      1'b0, 1'b0, 1'b0, 12'd0,    6'd0,  32'h0,         32'h0,         8'd0},
      '{op_check_all, 1'b0, 1'b0, 1'b0, 12'd0,    6'd0,  32'h0,         32'h0,         8'd0},
      // single events, one of them with ingress and egress together
      '{op_event,     1'b1, 1'b0, 1'b0, 12'd64,   6'd0,  32'h0,         32'h0,         8'd0},
      '{op_event,     1'b0, 1'b1, 1'b0, 12'd1500, 6'd0,  32'h0,         32'h0,         8'd0},
      '{op_event,     1'b1, 1'b1, 1'b0, 12'd1500, 6'd0,  32'h0,         32'h0,         8'd0},
      '{op_event,     1'b0, 1'b0, 1'b1, 12'd0,    6'd0,  32'h0,         32'h0,         8'd0},
      '{op_event,     1'b1, 1'b0, 1'b1, 12'd100,  6'd0,  32'h0,         32'h0,         8'd0},
      '{op_settle,    1'b0, 1'b0, 1'b0, 12'd0,    6'd0,  32'h0,         32'h0,         8'd0},
      '{op_check_all, 1'b0, 1'b0, 1'b0, 12'd0,    6'd0,  32'h0,         32'h0,         8'd0},
      // random traffic with idle bus
      '{op_random,    1'b0, 1'b0, 1'b0, 12'd0,    6'd0,  32'h0,         32'h0,         8'd30},
      '{op_settle,    1'b0, 1'b0, 1'b0, 12'd0,    6'd0,  32'h0,         32'h0,         8'd0},
      '{op_check_all, 1'b0, 1'b0, 1'b0, 12'd0,    6'd0,  32'h0,         32'h0,         8'd0},
      // random traffic under back-to-back reads
      '{op_busy,      1'b0, 1'b0, 1'b0, 12'd0,    6'd0,  32'h0,         32'h0,         8'd12},
      '{op_settle,    1'b0, 1'b0, 1'b0, 12'd0,    6'd0,  32'h0,         32'h0,         8'd0},
      '{op_check_all, 1'b0, 1'b0, 1'b0, 12'd0,    6'd0,  32'h0,         32'h0,         8'd0},
      // control register
      '{op_write,     1'b0, 1'b0, 1'b0, 12'd0,    6'd0,  32'h1,         32'h0,         8'd0},
      '{op_pins,      1'b0, 1'b0, 1'b0, 12'd0,    6'd0,  32'h0,         32'h1,         8'd0},
      '{op_read,      1'b0, 1'b0, 1'b0, 12'd0,    6'd0,  32'h0,         32'h1,         8'd0},
      '{op_write,     1'b0, 1'b0, 1'b0, 12'd0,    6'd0,  32'h3,         32'h0,         8'd0},
      '{op_pulse,     1'b0, 1'b0, 1'b0, 12'd0,    6'd0,  32'h0,         32'h0,         8'd0},
      '{op_read,      1'b0, 1'b0, 1'b0, 12'd0,    6'd0,  32'h0,         32'h1,         8'd0},
      '{op_write,     1'b0, 1'b0, 1'b0, 12'd0,    6'd0,  32'h0,         32'h0,         8'd0},
      '{op_pins,      1'b0, 1'b0, 1'b0, 12'd0,    6'd0,  32'h0,         32'h0,         8'd0},
      // preset counters, timeouts wrap past zero
      '{op_write,     1'b0, 1'b0, 1'b0, 12'd0,    6'd2,  32'h1000_0000, 32'h0,         8'd0},
      '{op_write,     1'b0, 1'b0, 1'b0, 12'd0,    6'd5,  32'hffff_fffa, 32'h0,         8'd0},
      '{op_random,    1'b0, 1'b0, 1'b0, 12'd0,    6'd0,  32'h0,         32'h0,         8'd20},
      '{op_settle,    1'b0, 1'b0, 1'b0, 12'd0,    6'd0,  32'h0,         32'h0,         8'd0},
      '{op_check_all, 1'b0, 1'b0, 1'b0, 12'd0,    6'd0,  32'h0,         32'h0,         8'd0},
      // unmapped addresses, 40 aliases address 0 in the low bits
      '{op_read,      1'b0, 1'b0, 1'b0, 12'd0,    6'd6,  32'h0,         32'hdead_beef, 8'd0},
      '{op_read,      1'b0, 1'b0, 1'b0, 12'd0,    6'd63, 32'h0,         32'hdead_beef, 8'd0},
      '{op_write,     1'b0, 1'b0, 1'b0, 12'd0,    6'd6,  32'h1234_5678, 32'h0,         8'd0},
      '{op_write,     1'b0, 1'b0, 1'b0, 12'd0,    6'd40, 32'h1,         32'h0,         8'd0},
      '{op_read,      1'b0, 1'b0, 1'b0, 12'd0,    6'd0,  32'h0,         32'h0,         8'd0},
      '{op_pins,      1'b0, 1'b0, 1'b0, 12'd0,    6'd0,  32'h0,         32'h0,         8'd0},
      '{op_check_all, 1'b0, 1'b0, 1'b0, 12'd0,    6'd0,  32'h0,         32'h0,         8'd0}
   };

   // reference totals, cycle count, pulse capture
   logic [data_width-1:0] ref_stats [num_stats] = '{default: '0};
   integer seed              = 32'h42c23654;
   int     errors            = 0;
   int     cycle             = 0;
   int     ack_cycle         = 0;
   int     reset_first_cycle = -1;
   int     reset_high_cycles = 0;

   `include "dma_stats_tb_tasks.svh"

   dma_stats_top dma_stats_top_i (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // --------------------------------------------------
   // monitors and timeout
   // --------------------------------------------------
   // length and start of the interface reset pulse
   always @(negedge clk) begin
      if (iface_reset) begin
         if (reset_high_cycles == 0)
            reset_first_cycle = cycle;
         reset_high_cycles++;
      end
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= timeout_cycles) begin
         $display("timeout, run stopped after %0d cycles without finishing", cycle);
         $display("TEST FAILED");
         $finish;
      end
   end

   // --------------------------------------------------
   // main sequence
   // --------------------------------------------------
   initial begin
      reset       = 1'b1;
      reg_req     = 1'b0;
      reg_rd_wr_l = 1'b1;
      reg_addr    = '0;
      reg_wr_data = '0;
      pkt_ingress = 1'b0;
      pkt_egress  = 1'b0;
      pkt_len     = '0;
      timeout     = 1'b0;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      // clear sweep
      repeat (8) @(posedge clk);

      foreach (stim[i]) begin
         case (stim[i].op)
            op_event:  drive_events(stim[i].ing, stim[i].egr, stim[i].tmo, stim[i].len);
            op_random: repeat (stim[i].cycles) random_step();
            op_write:  write_reg(stim[i].addr, stim[i].data);
            op_read:   check_read(stim[i].addr, stim[i].exp_data);
            op_busy:   busy_reads(stim[i].cycles);
            // every delta committed well within this
            op_settle: repeat (3 * num_regs) step_cycle(1'b0);
            op_check_all: begin
               for (int k = 0; k < num_stats; k++)
                  check_read(reg_addr_width'(k + 1), ref_stats[k]);
            end
            op_pins: begin
               step_cycle(1'b0);
               @(negedge clk);
               assert ({iface_reset, iface_disable} === stim[i].exp_data[1:0])
               else begin
                  errors++;
                  $display("Error at %0t: iface pins %b%b, expected %b", $time,
                           iface_reset, iface_disable, stim[i].exp_data[1:0]);
               end
            end
            op_pulse: begin
               while (iface_reset) begin
                  step_cycle(1'b0);
                  @(negedge clk);
               end
               // pulse starts in the ack cycle of the write
               assert (reset_high_cycles == reset_stretch_cycles &&
                       reset_first_cycle == ack_cycle)
               else begin
                  errors++;
                  $display("Error at %0t: iface_reset high %0d cycles from cycle %0d",
                           $time, reset_high_cycles, reset_first_cycle);
               end
            end
            default: begin
               errors++;
               $display("row %0d has an unknown kind", i);
            end
         endcase
      end
      step_cycle(1'b0);

      $display("run finished with %0d errors over %0d rows", errors, num_rows);
      if (errors == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule
